// File: hdl/cp0Pkg.sv
// Shared CP0 register numbers, exception kinds, ExcCode values and bus structs; referenced as cp0Pkg::name
package cp0Pkg;

    localparam int DataWidth = 32;

    // Register numbers as seen by mtc0/mfc0
    typedef enum logic [4:0] {
        RegBadVAddr = 5'd8,
        RegCount    = 5'd9,
        RegCompare  = 5'd11,
        RegStatus   = 5'd12,
        RegCause    = 5'd13,
        RegEpc      = 5'd14,
        RegPrid     = 5'd15
    } regAddr_e;

    // Committed exception kinds from the pipeline
    typedef enum logic [4:0] {
        ExcNone          = 5'd0,
        ExcInterrupt     = 5'd1,
        ExcAddrErrFetch  = 5'd2,
        ExcReservedInstr = 5'd3,
        ExcSyscall       = 5'd4,
        ExcBreak         = 5'd5,
        ExcTrap          = 5'd6,
        ExcOverflow      = 5'd7,
        ExcAddrErrStore  = 5'd8,
        ExcAddrErrLoad   = 5'd9,
        ExcEret          = 5'd10,
        ExcRefetch       = 5'd11
    } excType_e;

    // Cause.ExcCode values
    localparam logic [4:0] CodeInterrupt     = 5'h00;
    localparam logic [4:0] CodeAddrErrLoad   = 5'h04;  // Also used for fetch faults
    localparam logic [4:0] CodeAddrErrStore  = 5'h05;
    localparam logic [4:0] CodeSyscall       = 5'h08;
    localparam logic [4:0] CodeBreak         = 5'h09;
    localparam logic [4:0] CodeReservedInstr = 5'h0A;
    localparam logic [4:0] CodeOverflow      = 5'h0C;
    localparam logic [4:0] CodeTrap          = 5'h0D;

    // Committed mtc0
    typedef struct packed {
        logic                 valid;
        logic [4:0]           addr;
        logic [DataWidth-1:0] data;
    } cp0Write_t;

    // Committed exception
    typedef struct packed {
        excType_e             excType;
        logic [DataWidth-1:0] pc;
        logic                 inDelaySlot;
        logic [DataWidth-1:0] aluOut;  // Faulting data address
    } cp0Exception_t;

    typedef struct packed {
        logic count;
        logic compare;
        logic status;
        logic cause;
        logic epc;
        logic clearTi;
    } cp0WriteSel_t;

    typedef struct packed {
        logic       take;
        logic       eret;
        logic       badFromPc;
        logic       badFromAlu;
        logic       codeValid;
        logic [4:0] excCode;
    } cp0ExcFlags_t;

    // Fields the exception detector needs
    typedef struct packed {
        logic                 bev;
        logic [7:0]           im;
        logic                 exl;
        logic                 ie;
        logic [7:0]           ip;
        logic [DataWidth-1:0] epc;
    } cp0Flags_t;

endpackage

// File: hdl/cp0CommitDecode.sv
// Combinational decode of committed mtc0 writes and exceptions into CP0 strobes and flags
`timescale 1ns/100ps

module cp0CommitDecode (
    input  cp0Pkg::cp0Write_t     wr,
    input  cp0Pkg::cp0Exception_t exc,
    output cp0Pkg::cp0WriteSel_t  writeSel,
    output cp0Pkg::cp0ExcFlags_t  excFlags
);

    always_comb begin
        writeSel.count   = wr.valid && (wr.addr == cp0Pkg::RegCount);
        writeSel.compare = wr.valid && (wr.addr == cp0Pkg::RegCompare);
        writeSel.status  = wr.valid && (wr.addr == cp0Pkg::RegStatus);
        writeSel.cause   = wr.valid && (wr.addr == cp0Pkg::RegCause);
        writeSel.epc     = wr.valid && (wr.addr == cp0Pkg::RegEpc);
        writeSel.clearTi = writeSel.compare;  // Compare write acks the timer
    end

    always_comb begin
        excFlags.take       = (exc.excType != cp0Pkg::ExcNone) &&
                              (exc.excType != cp0Pkg::ExcRefetch);
        excFlags.eret       = (exc.excType == cp0Pkg::ExcEret);
        excFlags.badFromPc  = (exc.excType == cp0Pkg::ExcAddrErrFetch);
        excFlags.badFromAlu = (exc.excType == cp0Pkg::ExcAddrErrLoad) ||
                              (exc.excType == cp0Pkg::ExcAddrErrStore);
        excFlags.codeValid  = 1'b1;
        excFlags.excCode    = cp0Pkg::CodeInterrupt;
        case (exc.excType)
            cp0Pkg::ExcInterrupt:     excFlags.excCode = cp0Pkg::CodeInterrupt;
            cp0Pkg::ExcAddrErrFetch:  excFlags.excCode = cp0Pkg::CodeAddrErrLoad;
            cp0Pkg::ExcAddrErrLoad:   excFlags.excCode = cp0Pkg::CodeAddrErrLoad;
            cp0Pkg::ExcAddrErrStore:  excFlags.excCode = cp0Pkg::CodeAddrErrStore;
            cp0Pkg::ExcSyscall:       excFlags.excCode = cp0Pkg::CodeSyscall;
            cp0Pkg::ExcBreak:         excFlags.excCode = cp0Pkg::CodeBreak;
            cp0Pkg::ExcReservedInstr: excFlags.excCode = cp0Pkg::CodeReservedInstr;
            cp0Pkg::ExcOverflow:      excFlags.excCode = cp0Pkg::CodeOverflow;
            cp0Pkg::ExcTrap:          excFlags.excCode = cp0Pkg::CodeTrap;
            default: begin
                // None, Eret and Refetch leave ExcCode alone
                excFlags.codeValid = 1'b0;
            end
        endcase
    end

endmodule

// File: hdl/cp0Timer.sv
// CP0 Count/Compare timer with a clock divider on Count and the timer-interrupt compare
`timescale 1ns/100ps

module cp0Timer #(
    parameter int CountDivider = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  cp0Pkg::cp0WriteSel_t         writeSel,
    input  logic [cp0Pkg::DataWidth-1:0] wrData,
    output logic [cp0Pkg::DataWidth-1:0] count,
    output logic [cp0Pkg::DataWidth-1:0] compare,
    output logic                         timerIrq
);

    localparam int DivWidth = (CountDivider > 1) ? $clog2(CountDivider) : 1;
    localparam logic [DivWidth-1:0] DivLast = DivWidth'(CountDivider - 1);

    logic [DivWidth-1:0] divCount;
    logic                tick;
    logic                armed;  // Set once Compare has been written

    assign tick = (divCount == DivLast);

    always_ff @(posedge clk) begin
        if (reset) begin
            divCount <= '0;
        end else if (writeSel.count || tick) begin
            divCount <= '0;  // Restart phase on Count write
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (writeSel.count) begin
            count <= wrData;
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= '0;
            armed   <= 1'b0;
        end else if (writeSel.compare) begin
            compare <= wrData;
            armed   <= 1'b1;
        end
    end

    // Count == Compare right out of reset is not a real match
    assign timerIrq = armed && (count == compare);

endmodule

// File: hdl/cp0ExceptionState.sv
// CP0 Status, Cause, EPC and BadVAddr state, updated by exceptions and by mtc0 writes
`timescale 1ns/100ps

module cp0ExceptionState (
    input  logic                         clk,
    input  logic                         reset,
    input  cp0Pkg::cp0WriteSel_t         writeSel,
    input  logic [cp0Pkg::DataWidth-1:0] wrData,
    input  cp0Pkg::cp0ExcFlags_t         excFlags,
    input  cp0Pkg::cp0Exception_t        exc,
    input  logic [5:0]                   interrupt,
    input  logic                         timerIrq,
    output logic [cp0Pkg::DataWidth-1:0] status,
    output logic [cp0Pkg::DataWidth-1:0] cause,
    output logic [cp0Pkg::DataWidth-1:0] epc,
    output logic [cp0Pkg::DataWidth-1:0] badVAddr,
    output cp0Pkg::cp0Flags_t            flags
);

    logic       bev;
    logic [7:0] im;
    logic       exl;
    logic       ie;
    logic       bd;
    logic       ti;
    logic [5:0] ip72;
    logic [1:0] ip10;
    logic [4:0] excCode;
    logic       enter;  // Fresh exception entry captures EPC and BD

    assign enter = excFlags.take && !excFlags.eret && !exl;

    always_ff @(posedge clk) begin
        if (reset) begin
            bev <= 1'b1;
            im  <= '0;
            ie  <= 1'b0;
        end else if (writeSel.status) begin
            bev <= wrData[22];
            im  <= wrData[15:8];
            ie  <= wrData[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (excFlags.take) begin
            exl <= !excFlags.eret;  // Eret leaves exception level
        end else if (writeSel.status) begin
            exl <= wrData[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bd      <= 1'b0;
            ti      <= 1'b0;
            ip72    <= '0;
            ip10    <= '0;
            excCode <= '0;
        end else begin
            if (enter) bd <= exc.inDelaySlot;
            if (writeSel.clearTi) begin
                ti <= 1'b0;
            end else if (timerIrq) begin
                ti <= 1'b1;
            end
            ip72 <= interrupt | {timerIrq, 5'b0};  // Timer shares IP7
            if (writeSel.cause) ip10 <= wrData[9:8];  // Software interrupts
            if (excFlags.codeValid) excCode <= excFlags.excCode;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (enter) begin
            epc <= exc.inDelaySlot ? exc.pc - 32'd4 : exc.pc;  // Point at the branch
        end else if (writeSel.epc) begin
            epc <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badVAddr <= '0;
        end else if (excFlags.badFromPc) begin
            badVAddr <= exc.pc;
        end else if (excFlags.badFromAlu) begin
            badVAddr <= exc.aluOut;
        end
    end

    assign status = {9'b0, bev, 6'b0, im, 6'b0, exl, ie};
    assign cause  = {bd, ti, 14'b0, ip72, ip10, 1'b0, excCode, 2'b0};

    assign flags = '{bev: bev, im: im, exl: exl, ie: ie, ip: {ip72, ip10}, epc: epc};

endmodule

// File: hdl/cp0ReadMux.sv
// Combinational mfc0 read port selecting the addressed CP0 register
`timescale 1ns/100ps

module cp0ReadMux #(
    parameter logic [cp0Pkg::DataWidth-1:0] PridValue = 32'h0000_4220
) (
    input  cp0Pkg::regAddr_e             rdAddr,
    input  logic [cp0Pkg::DataWidth-1:0] count,
    input  logic [cp0Pkg::DataWidth-1:0] compare,
    input  logic [cp0Pkg::DataWidth-1:0] status,
    input  logic [cp0Pkg::DataWidth-1:0] cause,
    input  logic [cp0Pkg::DataWidth-1:0] epc,
    input  logic [cp0Pkg::DataWidth-1:0] badVAddr,
    output logic [cp0Pkg::DataWidth-1:0] rdData
);

    always_comb begin
        case (rdAddr)
            cp0Pkg::RegBadVAddr: rdData = badVAddr;
            cp0Pkg::RegCount:    rdData = count;
            cp0Pkg::RegCompare:  rdData = compare;
            cp0Pkg::RegStatus:   rdData = status;
            cp0Pkg::RegCause:    rdData = cause;
            cp0Pkg::RegEpc:      rdData = epc;
            cp0Pkg::RegPrid:     rdData = PridValue;  // Read-only
            default:             rdData = '0;  // Unimplemented registers
        endcase
    end

endmodule

// File: hdl/cp0Top.sv
// CP0 register block top level joining commit decode, timer, exception state and read port
`timescale 1ns/100ps

module cp0Top #(
    parameter int                           CountDivider = 2,
    parameter logic [cp0Pkg::DataWidth-1:0] PridValue    = 32'h0000_4220
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [5:0]                   interrupt,
    input  cp0Pkg::cp0Write_t            wr,
    input  cp0Pkg::cp0Exception_t        exc,
    input  cp0Pkg::regAddr_e             rdAddr,
    output logic [cp0Pkg::DataWidth-1:0] rdData,
    output cp0Pkg::cp0Flags_t            flags
);

    cp0Pkg::cp0WriteSel_t         writeSel;
    cp0Pkg::cp0ExcFlags_t         excFlags;
    logic [cp0Pkg::DataWidth-1:0] count;
    logic [cp0Pkg::DataWidth-1:0] compare;
    logic                         timerIrq;
    logic [cp0Pkg::DataWidth-1:0] status;
    logic [cp0Pkg::DataWidth-1:0] cause;
    logic [cp0Pkg::DataWidth-1:0] epc;
    logic [cp0Pkg::DataWidth-1:0] badVAddr;

    cp0CommitDecode decode (
        .wr(wr), .exc(exc), .writeSel(writeSel), .excFlags(excFlags)
    );

    cp0Timer #(.CountDivider(CountDivider)) timer (
        .clk(clk), .reset(reset), .writeSel(writeSel), .wrData(wr.data),
        .count(count), .compare(compare), .timerIrq(timerIrq)
    );

    cp0ExceptionState excState (
        .clk(clk), .reset(reset), .writeSel(writeSel), .wrData(wr.data),
        .excFlags(excFlags), .exc(exc), .interrupt(interrupt), .timerIrq(timerIrq),
        .status(status), .cause(cause), .epc(epc), .badVAddr(badVAddr), .flags(flags)
    );

    cp0ReadMux #(.PridValue(PridValue)) readMux (
        .rdAddr(rdAddr), .count(count), .compare(compare), .status(status),
        .cause(cause), .epc(epc), .badVAddr(badVAddr), .rdData(rdData)
    );

endmodule

// File: verification/cp0Regs_checker.sv
// Concurrent assertions on EXL around reset and exceptions, bound into cp0ExceptionState
`timescale 1ns/100ps

module cp0Regs_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 exl,
    input cp0Pkg::cp0ExcFlags_t excFlags
);

    // EXL comes out of reset clear
    resetClearsExl: assert property (@(posedge clk) reset |=> !exl)
        else $error("EXL set in the cycle after reset");

    takeSetsExl: assert property (@(posedge clk) disable iff (reset)
        excFlags.take && !excFlags.eret |=> exl)
        else $error("Taken exception did not set EXL");

    eretClearsExl: assert property (@(posedge clk) disable iff (reset)
        excFlags.eret |=> !exl)
        else $error("Eret did not clear EXL");

endmodule

bind cp0ExceptionState cp0Regs_checker regsCheck (
    .clk(clk), .reset(reset), .exl(exl), .excFlags(excFlags)
);

// File: verification/cp0Tb.sv
// Table-driven testbench for the CP0 register block, compiled through all.f with cp0Tb on top
`timescale 1ns/100ps

module cp0Tb;

    localparam logic [1:0] OpWrite = 2'd0;
    localparam logic [1:0] OpExc   = 2'd1;
    localparam logic [1:0] OpIdle  = 2'd2;
    localparam logic [1:0] OpCheck = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [4:0]  addr;  // Register number, or exception kind
        logic [31:0] data;  // Write data, or aluOut
        logic [31:0] pc;
        logic        ds;
        logic [5:0]  intr;
        logic [31:0] expected;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic [5:0]            interrupt;
    cp0Pkg::cp0Write_t     wr;
    cp0Pkg::cp0Exception_t exc;
    cp0Pkg::regAddr_e      rdAddr;
    logic [31:0]           rdData;
    cp0Pkg::cp0Flags_t     flags;

    row_t        rows[$];
    integer      seed;
    int          errors;
    int          checks;
    int          limitNs;
    logic [31:0] rnd;
    logic [31:0] statM;  // Expected Status with EXL clear
    logic [1:0]  ipLo;   // Software interrupt bits last written

    cp0Top uut (
        .clk(clk), .reset(reset), .interrupt(interrupt), .wr(wr), .exc(exc),
        .rdAddr(rdAddr), .rdData(rdData), .flags(flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cause layout with BD at 31, TI at 30, IP7..IP2 at 15:10, IP1..IP0 at 9:8, ExcCode at 6:2
    function automatic logic [31:0] causeWord(input logic bd, input logic ti,
                                              input logic [5:0] hi, input logic [4:0] code);
        return {bd, ti, 14'b0, hi, ipLo, 1'b0, code, 2'b0};
    endfunction

    task automatic addRow(input logic [1:0] op, input logic [4:0] addr, input logic [31:0] data,
                          input logic [31:0] pc, input logic ds, input logic [5:0] intr,
                          input logic [31:0] expected);
        row_t r;
        r = '{op, addr, data, pc, ds, intr, expected};
        rows.push_back(r);
    endtask

    task automatic addWrite(input logic [4:0] addr, input logic [31:0] data);
        addRow(OpWrite, addr, data, 32'h0, 1'b0, 6'h0, 32'h0);
    endtask

    task automatic addCheck(input logic [4:0] addr, input logic [31:0] expected);
        addRow(OpCheck, addr, 32'h0, 32'h0, 1'b0, 6'h0, expected);
    endtask

    task automatic addExc(input logic [4:0] kind, input logic [31:0] pc, input logic ds,
                          input logic [31:0] alu);
        addRow(OpExc, kind, alu, pc, ds, 6'h0, 32'h0);
    endtask

    task automatic buildTable();
        logic [31:0] v;
        addCheck(cp0Pkg::RegStatus, 32'h0040_0000);  // BEV only
        addCheck(cp0Pkg::RegCause, 32'h0);
        addCheck(cp0Pkg::RegPrid, 32'h0000_4220);
        addCheck(5'd3, 32'h0);  // Unmapped
        rnd = $random(seed);
        addWrite(cp0Pkg::RegCompare, rnd);
        addCheck(cp0Pkg::RegCompare, rnd);
        rnd = $random(seed);
        addWrite(cp0Pkg::RegEpc, rnd);
        addCheck(cp0Pkg::RegEpc, rnd);
        rnd = $random(seed);
        addWrite(cp0Pkg::RegStatus, rnd);
        addCheck(cp0Pkg::RegStatus, rnd & 32'h0040_FF03);
        rnd = $random(seed) & 32'hFFFF_FFFD;  // EXL clear before exception entry
        statM = rnd & 32'h0040_FF03;
        addWrite(cp0Pkg::RegStatus, rnd);
        addCheck(cp0Pkg::RegStatus, statM);
        rnd = $random(seed) | 32'h0000_0100;  // Nonzero software interrupt bits
        ipLo = rnd[9:8];
        addWrite(cp0Pkg::RegCause, rnd);
        addCheck(cp0Pkg::RegCause, causeWord(1'b0, 1'b0, 6'h0, 5'h0));
        v = $random(seed);
        addWrite(cp0Pkg::RegCount, v);
        for (int m = 0; m < 6; m++) begin
            addCheck(cp0Pkg::RegCount, v + m / 2);  // One step every second edge
        end
        v = $random(seed);
        addWrite(cp0Pkg::RegCount, v);
        addWrite(cp0Pkg::RegCompare, v + 32'd3);
        repeat (6) addRow(OpIdle, 5'd0, 32'h0, 32'h0, 1'b0, 6'h0, 32'h0);
        addCheck(cp0Pkg::RegCause, causeWord(1'b0, 1'b1, 6'h20, 5'h0));
        rnd = $random(seed);
        addWrite(cp0Pkg::RegCompare, rnd);
        addCheck(cp0Pkg::RegCause, causeWord(1'b0, 1'b0, 6'h0, 5'h0));
        addExc(cp0Pkg::ExcSyscall, 32'h8000_1000, 1'b0, 32'h0);
        addCheck(cp0Pkg::RegStatus, statM | 32'h2);
        addCheck(cp0Pkg::RegEpc, 32'h8000_1000);
        addCheck(cp0Pkg::RegCause, causeWord(1'b0, 1'b0, 6'h0, 5'h08));
        addExc(cp0Pkg::ExcEret, 32'h0, 1'b0, 32'h0);
        addCheck(cp0Pkg::RegStatus, statM);
        addExc(cp0Pkg::ExcOverflow, 32'h8000_2004, 1'b1, 32'h0);
        addCheck(cp0Pkg::RegEpc, 32'h8000_2000);
        addCheck(cp0Pkg::RegCause, causeWord(1'b1, 1'b0, 6'h0, 5'h0C));
        addExc(cp0Pkg::ExcBreak, 32'h8000_3000, 1'b0, 32'h0);  // Nested entry keeps EPC and BD
        addCheck(cp0Pkg::RegEpc, 32'h8000_2000);
        addCheck(cp0Pkg::RegCause, causeWord(1'b1, 1'b0, 6'h0, 5'h09));
        addExc(cp0Pkg::ExcEret, 32'h0, 1'b0, 32'h0);
        addExc(cp0Pkg::ExcAddrErrLoad, 32'h8000_4000, 1'b0, 32'h1234_5679);
        addCheck(cp0Pkg::RegBadVAddr, 32'h1234_5679);
        addCheck(cp0Pkg::RegCause, causeWord(1'b0, 1'b0, 6'h0, 5'h04));
        addExc(cp0Pkg::ExcAddrErrFetch, 32'h8000_5002, 1'b0, 32'h0);
        addCheck(cp0Pkg::RegBadVAddr, 32'h8000_5002);
        addCheck(cp0Pkg::RegEpc, 32'h8000_4000);
        // External lines show up one edge late
        addRow(OpCheck, cp0Pkg::RegCause, 32'h0, 32'h0, 1'b0, 6'h2B,
               causeWord(1'b0, 1'b0, 6'h0, 5'h04));
        addRow(OpCheck, cp0Pkg::RegCause, 32'h0, 32'h0, 1'b0, 6'h2B,
               causeWord(1'b0, 1'b0, 6'h2B, 5'h04));
        addRow(OpIdle, 5'd0, 32'h0, 32'h0, 1'b0, 6'h0, 32'h0);
        addCheck(cp0Pkg::RegCause, causeWord(1'b0, 1'b0, 6'h0, 5'h04));
    endtask

    task automatic applyRow(input row_t r);
        wr        = '0;
        exc       = '0;
        interrupt = r.intr;
        if (r.op == OpWrite) wr = '{valid: 1'b1, addr: r.addr, data: r.data};
        if (r.op == OpExc) begin
            exc = '{excType: cp0Pkg::excType_e'(r.addr), pc: r.pc, inDelaySlot: r.ds,
                    aluOut: r.data};
        end
        if (r.op == OpCheck) rdAddr = cp0Pkg::regAddr_e'(r.addr);
    endtask

    // Exported fields must match the register value this row expects
    task automatic checkFlags(input row_t r);
        logic [10:0] wantStat;
        wantStat = {r.expected[22], r.expected[15:8], r.expected[1:0]};
        case (r.addr)
            cp0Pkg::RegStatus: begin
                checks++;
                if ({flags.bev, flags.im, flags.exl, flags.ie} !== wantStat) begin
                    errors++;
                    $display("FAIL flags.bev/im/exl/ie: got %h, expected %h",
                             {flags.bev, flags.im, flags.exl, flags.ie}, wantStat);
                end
            end
            cp0Pkg::RegCause: begin
                checks++;
                if (flags.ip !== r.expected[15:8]) begin
                    errors++;
                    $display("FAIL flags.ip: got %h, expected %h", flags.ip, r.expected[15:8]);
                end
            end
            cp0Pkg::RegEpc: begin
                checks++;
                if (flags.epc !== r.expected) begin
                    errors++;
                    $display("FAIL flags.epc: got %h, expected %h", flags.epc, r.expected);
                end
            end
            default: ;
        endcase
    endtask

    task automatic checkRead(input row_t r);
        checks++;
        if (rdData !== r.expected) begin
            errors++;
            $display("FAIL rdData (rdAddr %h): got %h, expected %h", r.addr, rdData, r.expected);
        end
        checkFlags(r);
    endtask

    initial begin
        seed      = 32'h60ea1e83;
        errors    = 0;
        checks    = 0;
        limitNs   = 0;
        reset     = 1'b1;
        interrupt = '0;
        wr        = '0;
        exc       = '0;
        rdAddr    = cp0Pkg::RegStatus;
        buildTable();
        limitNs = (rows.size() + 16) * 10 + 500;  // Reset plus one cycle per row, with margin
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            #1 applyRow(rows[i]);
            if (rows[i].op == OpCheck) begin
                #4 checkRead(rows[i]);
            end
        end
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        wait (limitNs > 0);
        #(limitNs);
        $display("Timeout: the stimulus table did not finish within %0d ns", limitNs);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: all.f
hdl/cp0Pkg.sv
hdl/cp0CommitDecode.sv
hdl/cp0Timer.sv
hdl/cp0ExceptionState.sv
hdl/cp0ReadMux.sv
hdl/cp0Top.sv
verification/cp0Regs_checker.sv
verification/cp0Tb.sv

// File: Makefile
# Verilator build and run for the CP0 register block

VERILATOR ?= verilator
TOP       ?= cp0Tb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
